// File: src/exu_pkg.sv
//////////////////////////////
// Widths and depths of the stage, RV32I major
// opcodes, the operation enum and the structs
// passed between decode, execute and write-back
//////////////////////////////
`default_nettype none

package exu_pkg;

  localparam int XLEN       = 32;
  localparam int INSTR_W    = 32;
  localparam int RFIDX_W    = 5;
  localparam int OITF_DEPTH = 4;
  localparam int ITAG_W     = 2;   // Index into the OITF

  // RV32I major opcodes handled here
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB and SRA

  //////////////////////////////
  // Operation or instruction kind
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_LUI,
    OP_LOAD,
    OP_ILLEGAL
  } opcode_e;

  //////////////////////////////
  // Decoded instruction
  typedef struct packed {
    opcode_e            op;
    logic               rs1en;
    logic               rs2en;
    logic               rdwen;    // Never set for x0
    logic [RFIDX_W-1:0] rdidx;
    logic               use_imm;  // Operand b from imm
    logic [XLEN-1:0]    imm;
  } dec_info_t;

  // Load command to the load unit
  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [ITAG_W-1:0] itag;
  } lsu_cmd_t;

  // ALU result waiting for the write port
  typedef struct packed {
    logic               valid;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } alu_wbck_t;

  // One register file write
  typedef struct packed {
    logic               ena;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } wbck_t;

endpackage

`default_nettype wire

// File: src/exu_decode.sv
//////////////////////////////
// Decoder for the OP, OP-IMM, LUI and LW
// subset of RV32I
//////////////////////////////
`default_nettype none

module exu_decode (
  input  wire logic [exu_pkg::INSTR_W-1:0] i_ir,
  output exu_pkg::dec_info_t               o_info,
  output logic [exu_pkg::RFIDX_W-1:0]      o_rs1idx,
  output logic [exu_pkg::RFIDX_W-1:0]      o_rs2idx
);
  import exu_pkg::*;

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [RFIDX_W-1:0] rd;
  logic               is_op;
  logic               is_shift;
  logic               alt_ok;    // funct3 that may carry F7_ALT
  logic               alu_ok;    // funct7 legal for this encoding
  logic               rd_used;
  opcode_e            alu_op;
  logic [XLEN-1:0]    imm_i;
  logic [XLEN-1:0]    imm_u;

  assign opcode   = i_ir[6:0];
  assign rd       = i_ir[11:7];
  assign funct3   = i_ir[14:12];
  assign funct7   = i_ir[31:25];
  assign o_rs1idx = i_ir[19:15];
  assign o_rs2idx = i_ir[24:20];

  assign imm_i = {{(XLEN-12){i_ir[31]}}, i_ir[31:20]};
  assign imm_u = {i_ir[31:12], 12'b0};

  // funct7 only matters for OP and for the immediate shifts
  assign is_op    = (opcode == OPC_OP);
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign alt_ok   = (funct3 == 3'b101) || (is_op && funct3 == 3'b000);
  assign alu_ok   = (!is_op && !is_shift) || (funct7 == '0) ||
                    (funct7 == F7_ALT && alt_ok);

  always_comb begin
    case (funct3)
      3'b000:  alu_op = (is_op && funct7 == F7_ALT) ? OP_SUB : OP_ADD;
      3'b001:  alu_op = OP_SLL;
      3'b010:  alu_op = OP_SLT;
      3'b011:  alu_op = OP_SLTU;
      3'b100:  alu_op = OP_XOR;
      3'b101:  alu_op = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
      3'b110:  alu_op = OP_OR;
      default: alu_op = OP_AND;
    endcase
  end

  always_comb begin
    o_info    = '0;
    o_info.op = OP_ILLEGAL;
    rd_used   = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        if (alu_ok) begin
          o_info.op      = alu_op;
          o_info.rs1en   = 1'b1;
          o_info.rs2en   = is_op;
          o_info.use_imm = !is_op;
          o_info.imm     = imm_i;
          rd_used        = 1'b1;
        end
      end
      OPC_LUI: begin
        o_info.op      = OP_LUI;
        o_info.use_imm = 1'b1;
        o_info.imm     = imm_u;
        rd_used        = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == F3_LW) begin
          o_info.op      = OP_LOAD;
          o_info.rs1en   = 1'b1;
          o_info.use_imm = 1'b1;
          o_info.imm     = imm_i;
          rd_used        = 1'b1;
        end
      end
      default: ;
    endcase
    // rdidx reads as zero whenever nothing is written
    o_info.rdwen = rd_used && (rd != '0);
    o_info.rdidx = o_info.rdwen ? rd : '0;
  end

endmodule

`default_nettype wire

// File: src/exu_regfile.sv
//////////////////////////////
// Integer register file, 2 read ports
// and 1 write port, x0 reads as zero
//////////////////////////////
`default_nettype none

module exu_regfile (
  input  wire logic                        clk,
  input  wire logic                        i_rst,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  output logic [exu_pkg::XLEN-1:0]         o_rs1,
  output logic [exu_pkg::XLEN-1:0]         o_rs2,
  input  wire exu_pkg::wbck_t              i_wbck
);
  import exu_pkg::*;

  logic [XLEN-1:0] rf_q [1:2**RFIDX_W-1];  // No storage for x0

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < 2**RFIDX_W; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.ena && i_wbck.rdidx != '0) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  // Plain reads, a write lands one edge later
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

`default_nettype wire

// File: src/exu_execute.sv
//////////////////////////////
// Dispatch with hazard stalls, the
// single-cycle ALU and its result register
//////////////////////////////
`default_nettype none

module exu_execute (
  input  wire logic                        clk,
  input  wire logic                        i_rst,
  input  wire logic                        i_valid,
  input  wire exu_pkg::dec_info_t          i_info,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  input  wire logic [exu_pkg::XLEN-1:0]    i_rs1,
  input  wire logic [exu_pkg::XLEN-1:0]    i_rs2,
  input  wire logic                        i_oitf_match,
  input  wire logic                        i_oitf_full,
  input  wire logic [exu_pkg::ITAG_W-1:0]  i_oitf_ptr,
  input  wire logic                        i_lsu_cmd_ready,
  input  wire logic                        i_alu_grant,
  output logic                             o_ready,
  output logic                             o_lsu_cmd_valid,
  output exu_pkg::lsu_cmd_t                o_lsu_cmd,
  output logic                             o_oitf_alloc,
  output exu_pkg::alu_wbck_t               o_alu_wbck,
  output logic                             o_ilegl
);
  import exu_pkg::*;

  logic               is_load;
  logic               is_alu;
  logic               src_hit;   // Source waits on the pending result
  logic               rd_hit;    // Load would overtake the pending result
  logic               alu_busy;
  logic               load_ok;
  logic               accept;
  logic [XLEN-1:0]    op_b;
  logic [XLEN-1:0]    alu_res;
  logic               res_vld_q;
  logic [RFIDX_W-1:0] res_rd_q;
  logic [XLEN-1:0]    res_dat_q;

  assign is_load = (i_info.op == OP_LOAD);
  assign is_alu  = !is_load && (i_info.op != OP_ILLEGAL);

  //////////////////////////////
  // Dispatch
  assign src_hit  = res_vld_q &&
                    ((i_info.rs1en && i_rs1idx == res_rd_q) ||
                     (i_info.rs2en && i_rs2idx == res_rd_q));
  assign rd_hit   = res_vld_q && i_info.rdwen && (i_info.rdidx == res_rd_q);
  assign alu_busy = res_vld_q && !i_alu_grant;

  assign load_ok = is_load && !i_oitf_match && !src_hit && !rd_hit && !i_oitf_full;

  always_comb begin
    if (is_load) begin
      o_ready = load_ok && i_lsu_cmd_ready;  // Held until the load unit takes it
    end else begin
      o_ready = !i_oitf_match && !src_hit && !(is_alu && alu_busy);
    end
  end

  assign accept          = i_valid && o_ready;
  assign o_lsu_cmd_valid = i_valid && load_ok;
  assign o_oitf_alloc    = accept && is_load;
  assign o_ilegl         = accept && (i_info.op == OP_ILLEGAL);

  //////////////////////////////
  // ALU, the adder also forms load addresses
  assign op_b = i_info.use_imm ? i_info.imm : i_rs2;

  always_comb begin
    case (i_info.op)
      OP_ADD, OP_LOAD: alu_res = i_rs1 + op_b;
      OP_SUB:          alu_res = i_rs1 - op_b;
      OP_AND:          alu_res = i_rs1 & op_b;
      OP_OR:           alu_res = i_rs1 | op_b;
      OP_XOR:          alu_res = i_rs1 ^ op_b;
      OP_SLL:          alu_res = i_rs1 << op_b[4:0];
      OP_SRL:          alu_res = i_rs1 >> op_b[4:0];
      OP_SRA:          alu_res = $signed(i_rs1) >>> op_b[4:0];
      OP_SLT:          alu_res = XLEN'($signed(i_rs1) < $signed(op_b));
      OP_SLTU:         alu_res = XLEN'(i_rs1 < op_b);
      OP_LUI:          alu_res = op_b;
      default:         alu_res = '0;
    endcase
  end

  assign o_lsu_cmd.addr = alu_res;
  assign o_lsu_cmd.itag = i_oitf_ptr;

  // Result register, a new fill wins over the grant
  always_ff @(posedge clk) begin
    if (i_rst) begin
      res_vld_q <= 1'b0;
    end else if (accept && is_alu) begin
      res_vld_q <= i_info.rdwen;
    end else if (i_alu_grant) begin
      res_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_alu) begin
      res_rd_q  <= i_info.rdidx;
      res_dat_q <= alu_res;
    end
  end

  assign o_alu_wbck.valid = res_vld_q;
  assign o_alu_wbck.rdidx = res_rd_q;
  assign o_alu_wbck.wdat  = res_dat_q;

endmodule

`default_nettype wire

// File: src/exu_oitf.sv
//////////////////////////////
// Table of outstanding loads, kept
// in issue order, with dependency match
//////////////////////////////
`default_nettype none

module exu_oitf (
  input  wire logic                        clk,
  input  wire logic                        i_rst,
  input  wire logic                        i_alloc,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_alloc_rdidx,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  input  wire logic                        i_rs1en,
  input  wire logic                        i_rs2en,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_rdidx,
  input  wire logic                        i_ret,
  output logic                             o_match,
  output logic                             o_full,
  output logic [exu_pkg::ITAG_W-1:0]       o_ptr,
  output logic [exu_pkg::RFIDX_W-1:0]      o_ret_rdidx
);
  import exu_pkg::*;

  logic [RFIDX_W-1:0]    rd_q [OITF_DEPTH];
  logic [OITF_DEPTH-1:0] vld_q;
  logic [OITF_DEPTH-1:0] vld_nxt;
  logic [OITF_DEPTH-1:0] hit;
  logic [ITAG_W:0]       alc_q;   // Wrap bit on top of the index
  logic [ITAG_W:0]       ret_q;

  // Step an index, toggling the wrap bit at the last entry
  function automatic logic [ITAG_W:0] ptr_next(input logic [ITAG_W:0] p);
    if (p[ITAG_W-1:0] == ITAG_W'(OITF_DEPTH-1)) begin
      return {~p[ITAG_W], {ITAG_W{1'b0}}};
    end
    return p + 1'b1;
  endfunction

  always_comb begin
    vld_nxt = vld_q;
    if (i_ret) begin
      vld_nxt[ret_q[ITAG_W-1:0]] = 1'b0;
    end
    if (i_alloc) begin
      vld_nxt[alc_q[ITAG_W-1:0]] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      alc_q <= '0;
      ret_q <= '0;
      vld_q <= '0;
    end else begin
      if (i_alloc) alc_q <= ptr_next(alc_q);
      if (i_ret)   ret_q <= ptr_next(ret_q);
      vld_q <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (i_alloc) begin
      rd_q[alc_q[ITAG_W-1:0]] <= i_alloc_rdidx;
    end
  end

  //////////////////////////////
  // Dependency match, x0 never blocks
  always_comb begin
    for (int i = 0; i < OITF_DEPTH; i++) begin
      hit[i] = vld_q[i] && (rd_q[i] != '0) &&
               ((i_rs1en && i_rs1idx == rd_q[i]) ||
                (i_rs2en && i_rs2idx == rd_q[i]) ||
                (i_rdidx == rd_q[i]));
    end
  end

  assign o_match     = |hit;
  assign o_full      = (alc_q[ITAG_W-1:0] == ret_q[ITAG_W-1:0]) &&
                       (alc_q[ITAG_W] != ret_q[ITAG_W]);
  assign o_ptr       = alc_q[ITAG_W-1:0];
  assign o_ret_rdidx = rd_q[ret_q[ITAG_W-1:0]];  // Oldest load

endmodule

`default_nettype wire

// File: src/exu_wbck.sv
//////////////////////////////
// Final write-back, load returns
// first, then the ALU result
//////////////////////////////
`default_nettype none

module exu_wbck (
  input  wire logic                        i_lsu_wbck_valid,
  input  wire logic [exu_pkg::XLEN-1:0]    i_lsu_wbck_wdat,
  input  wire logic [exu_pkg::RFIDX_W-1:0] i_ret_rdidx,
  input  wire exu_pkg::alu_wbck_t          i_alu_wbck,
  output logic                             o_alu_grant,
  output exu_pkg::wbck_t                   o_wbck
);
  import exu_pkg::*;

  // ALU result waits whenever a load comes back
  assign o_alu_grant = i_alu_wbck.valid && !i_lsu_wbck_valid;

  always_comb begin
    if (i_lsu_wbck_valid) begin
      o_wbck.ena   = (i_ret_rdidx != '0);  // Load to x0 is dropped
      o_wbck.rdidx = i_ret_rdidx;
      o_wbck.wdat  = i_lsu_wbck_wdat;
    end else begin
      o_wbck.ena   = i_alu_wbck.valid;
      o_wbck.rdidx = i_alu_wbck.rdidx;
      o_wbck.wdat  = i_alu_wbck.wdat;
    end
  end

endmodule

`default_nettype wire

// File: src/exu_top.sv
//////////////////////////////
// Top of the execution stage
//////////////////////////////
`default_nettype none

module exu_top (
  input  wire logic                        clk,
  input  wire logic                        i_rst,
  input  wire logic                        i_valid,
  output logic                             o_ready,
  input  wire logic [exu_pkg::INSTR_W-1:0] i_ir,
  output logic                             o_lsu_cmd_valid,
  input  wire logic                        i_lsu_cmd_ready,
  output exu_pkg::lsu_cmd_t                o_lsu_cmd,
  input  wire logic                        i_lsu_wbck_valid,
  input  wire logic [exu_pkg::XLEN-1:0]    i_lsu_wbck_wdat,
  output exu_pkg::wbck_t                   o_wbck,
  output logic                             o_ilegl
);
  import exu_pkg::*;

  dec_info_t          dec_info;
  logic [RFIDX_W-1:0] dec_rs1idx;
  logic [RFIDX_W-1:0] dec_rs2idx;
  logic [XLEN-1:0]    rf_rs1;
  logic [XLEN-1:0]    rf_rs2;
  logic               oitf_match;
  logic               oitf_full;
  logic [ITAG_W-1:0]  oitf_ptr;
  logic               oitf_alloc;
  logic [RFIDX_W-1:0] oitf_ret_rdidx;
  alu_wbck_t          alu_wbck;
  logic               alu_grant;

  //////////////////////////////
  // Decode and operand read
  exu_decode u_decode (
    .i_ir     (i_ir),
    .o_info   (dec_info),
    .o_rs1idx (dec_rs1idx),
    .o_rs2idx (dec_rs2idx)
  );

  exu_regfile u_regfile (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_rs1idx (dec_rs1idx),
    .i_rs2idx (dec_rs2idx),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2),
    .i_wbck   (o_wbck)     // Same write as the output
  );

  //////////////////////////////
  // Dispatch, ALU and load tracking
  exu_execute u_execute (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_info          (dec_info),
    .i_rs1idx        (dec_rs1idx),
    .i_rs2idx        (dec_rs2idx),
    .i_rs1           (rf_rs1),
    .i_rs2           (rf_rs2),
    .i_oitf_match    (oitf_match),
    .i_oitf_full     (oitf_full),
    .i_oitf_ptr      (oitf_ptr),
    .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .i_alu_grant     (alu_grant),
    .o_ready         (o_ready),
    .o_lsu_cmd_valid (o_lsu_cmd_valid),
    .o_lsu_cmd       (o_lsu_cmd),
    .o_oitf_alloc    (oitf_alloc),
    .o_alu_wbck      (alu_wbck),
    .o_ilegl         (o_ilegl)
  );

  exu_oitf u_oitf (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_alloc       (oitf_alloc),
    .i_alloc_rdidx (dec_info.rdidx),
    .i_rs1idx      (dec_rs1idx),
    .i_rs2idx      (dec_rs2idx),
    .i_rs1en       (dec_info.rs1en),
    .i_rs2en       (dec_info.rs2en),
    .i_rdidx       (dec_info.rdidx),
    .i_ret         (i_lsu_wbck_valid),  // Returns come back in order
    .o_match       (oitf_match),
    .o_full        (oitf_full),
    .o_ptr         (oitf_ptr),
    .o_ret_rdidx   (oitf_ret_rdidx)
  );

  exu_wbck u_wbck (
    .i_lsu_wbck_valid (i_lsu_wbck_valid),
    .i_lsu_wbck_wdat  (i_lsu_wbck_wdat),
    .i_ret_rdidx      (oitf_ret_rdidx),
    .i_alu_wbck       (alu_wbck),
    .o_alu_grant      (alu_grant),
    .o_wbck           (o_wbck)
  );

endmodule

`default_nettype wire

// File: tb/tb_exu.sv
//////////////////////////////
// Testbench for the execution stage with a load
// unit model, an RV32I reference model and a watchdog
//////////////////////////////
`default_nettype none

module tb_exu;
  import exu_pkg::*;

  localparam logic [6:0] RV_OP     = 7'b0110011;
  localparam logic [6:0] RV_OP_IMM = 7'b0010011;
  localparam logic [6:0] RV_LUI    = 7'b0110111;
  localparam logic [6:0] RV_LOAD   = 7'b0000011;
  localparam logic [31:0] RET_XOR  = 32'hA5A5_0000;  // Load data pattern
  localparam int MAX_INSTR    = 140;  // Upper bound over all tests
  localparam int WATCHDOG_CYC = 200 * MAX_INSTR + 1000;

  logic        clk = 1'b0;
  logic        i_rst = 1'b1;
  logic        i_valid = 1'b0;
  logic [31:0] i_ir = 32'h0;
  logic        i_lsu_cmd_ready = 1'b0;
  logic        i_lsu_wbck_valid = 1'b0;
  logic [31:0] i_lsu_wbck_wdat = 32'h0;
  logic        o_ready;
  logic        o_lsu_cmd_valid;
  lsu_cmd_t    o_lsu_cmd;
  wbck_t       o_wbck;
  logic        o_ilegl;

  logic [31:0] lfsr_q = 32'h741f_50b3;
  logic [31:0] ref_rf [32];
  logic [36:0] alu_q [$];      // Expected ALU writes {rd, data}
  logic [36:0] ld_q [$];       // Expected load writes {rd, data}
  logic [31:0] exp_addr_q [$];
  logic [31:0] lsu_addr_q [$];
  int          lsu_due_q [$];
  int          cyc = 0;
  int          err_cnt = 0;
  int          err_start = 0;
  int          chk_cnt = 0;
  int          n_tests = 0;
  int          n_illegal = 0;
  int          ilegl_cnt = 0;
  int          n_loads = 0;    // Load commands taken so far
  logic        gap_en = 1'b0;
  logic        gap_s;
  logic        rst_s;
  string       test_name = "reset";

  exu_top dut0 (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_valid          (i_valid),
    .o_ready          (o_ready),
    .i_ir             (i_ir),
    .o_lsu_cmd_valid  (o_lsu_cmd_valid),
    .i_lsu_cmd_ready  (i_lsu_cmd_ready),
    .o_lsu_cmd        (o_lsu_cmd),
    .i_lsu_wbck_valid (i_lsu_wbck_valid),
    .i_lsu_wbck_wdat  (i_lsu_wbck_wdat),
    .o_wbck           (o_wbck),
    .o_ilegl          (o_ilegl)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Helpers
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = 32'h0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), RV_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic logic [31:0] u_type(input int rd, input logic [19:0] imm);
    return {imm, 5'(rd), RV_LUI};
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // RV32I semantics, expected writes queued in program order
  task automatic model_issue(input logic [31:0] ir);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        legal;
    opc = ir[6:0];
    f3  = ir[14:12];
    f7  = ir[31:25];
    rd  = ir[11:7];
    a   = ref_rf[ir[19:15]];
    b   = (opc == RV_OP) ? ref_rf[ir[24:20]] : {{20{ir[31]}}, ir[31:20]};
    case (opc)
      RV_OP:     legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      RV_OP_IMM: legal = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 ||
                         (f7 == 7'h20 && f3 == 3'd5);
      RV_LUI:    legal = 1'b1;
      RV_LOAD:   legal = (f3 == 3'd2);
      default:   legal = 1'b0;
    endcase
    case (f3)
      3'd0:    res = (opc == RV_OP && ir[30]) ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = {31'b0, $signed(a) < $signed(b)};
      3'd3:    res = {31'b0, a < b};
      3'd4:    res = a ^ b;
      3'd5: begin
        if (ir[30]) begin
          res = $signed(a) >>> b[4:0];  // Sign fills from the top
        end else begin
          res = a >> b[4:0];
        end
      end
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    if (opc == RV_LUI) res = {ir[31:12], 12'b0};
    if (!legal) begin
      n_illegal++;
    end else if (opc == RV_LOAD) begin
      exp_addr_q.push_back(a + b);
      res = (a + b) ^ RET_XOR;
      if (rd != 5'd0) ld_q.push_back({rd, res});
    end else if (rd != 5'd0) begin
      alu_q.push_back({rd, res});
    end
    if (legal && rd != 5'd0) ref_rf[rd] = res;
  endtask

  // Called one time unit after a rising edge
  task automatic send(input logic [31:0] ir);
    model_issue(ir);
    i_valid = 1'b1;
    i_ir    = ir;
    do @(negedge clk);
    while (!o_ready);
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  task automatic drain();
    do @(negedge clk);
    while (alu_q.size() != 0 || ld_q.size() != 0 || lsu_addr_q.size() != 0);
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = err_cnt;
    n_tests++;
  endtask

  task automatic end_test();
    drain();
    $display("Test %s finished with %0d errors", test_name, err_cnt - err_start);
  endtask

  //////////////////////////////
  // Load unit model, returns in order after 1 to 4 cycles
  always @(posedge clk) begin
    cyc++;
    gap_s = gap_en;
    rst_s = i_rst;
    #1;
    i_lsu_wbck_valid = 1'b0;
    if (rst_s) begin
      i_lsu_cmd_ready = 1'b0;
    end else begin
      i_lsu_cmd_ready = gap_s ? (rand_bits(2) != 32'd0) : 1'b1;
      if (lsu_addr_q.size() > 0 && cyc >= lsu_due_q[0]) begin
        i_lsu_wbck_valid = 1'b1;
        i_lsu_wbck_wdat  = lsu_addr_q.pop_front() ^ RET_XOR;
        void'(lsu_due_q.pop_front());
      end
    end
  end

  // Monitor, everything here lands at the next rising edge
  always @(negedge clk) begin
    if (!i_rst) begin
      if (o_lsu_cmd_valid && i_lsu_cmd_ready) begin
        if (exp_addr_q.size() == 0) begin
          report_error("load command sent with no load issued");
        end else begin
          check("load address", 64'(exp_addr_q.pop_front()), 64'(o_lsu_cmd.addr));
        end
        // Tags walk the table in issue order
        check("load tag", 64'(n_loads % OITF_DEPTH), 64'(o_lsu_cmd.itag));
        n_loads++;
        lsu_addr_q.push_back(o_lsu_cmd.addr);
        lsu_due_q.push_back(cyc + 2 + int'(rand_bits(2)));
      end
      if (o_ilegl) ilegl_cnt++;
      if (o_wbck.ena) begin
        if (o_wbck.rdidx == 5'd0) begin
          report_error("write to x0 on the write-back port");
        end else if (i_lsu_wbck_valid) begin
          if (ld_q.size() == 0) report_error("load write with none expected");
          else check("load write", 64'(ld_q.pop_front()), 64'({o_wbck.rdidx, o_wbck.wdat}));
        end else begin
          if (alu_q.size() == 0) report_error("ALU write with none expected");
          else check("ALU write", 64'(alu_q.pop_front()), 64'({o_wbck.rdidx, o_wbck.wdat}));
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout after %0d cycles, the stage stopped making progress", WATCHDOG_CYC);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Tests
  task automatic test_alu_ops();
    begin_test("alu_ops");
    send(u_type(1, 20'h87654));
    send(i_type(RV_OP_IMM, 0, 1, 1, 'h321));
    send(i_type(RV_OP_IMM, 0, 2, 0, 19));
    send(i_type(RV_OP_IMM, 0, 3, 0, -5));
    send(r_type('h00, 0, 4, 1, 2));      // ADD
    send(r_type('h20, 0, 5, 1, 3));      // SUB
    send(r_type('h00, 7, 6, 1, 3));
    send(r_type('h00, 6, 7, 2, 3));
    send(r_type('h00, 4, 8, 1, 3));
    send(r_type('h00, 1, 9, 1, 2));      // SLL
    send(r_type('h00, 5, 10, 1, 2));
    send(r_type('h20, 5, 11, 1, 2));     // SRA
    send(r_type('h00, 2, 12, 1, 3));
    send(r_type('h00, 3, 13, 1, 3));
    send(i_type(RV_OP_IMM, 2, 14, 3, -4));
    send(i_type(RV_OP_IMM, 3, 15, 2, 20));
    send(i_type(RV_OP_IMM, 4, 16, 1, -1));
    send(i_type(RV_OP_IMM, 6, 17, 2, 'h700));
    send(i_type(RV_OP_IMM, 7, 18, 1, 'h0f0));
    send(i_type(RV_OP_IMM, 1, 19, 2, 7));
    send(i_type(RV_OP_IMM, 5, 20, 1, 8));
    send(i_type(RV_OP_IMM, 5, 21, 1, 'h40c));  // SRAI by 12
    end_test();
  endtask

  task automatic test_x0();
    begin_test("x0_handling");
    send(i_type(RV_OP_IMM, 0, 0, 1, 5));
    send(r_type('h00, 0, 0, 1, 2));
    send(u_type(0, 20'h12345));
    send(i_type(RV_LOAD, 2, 0, 2, 0));   // Load with no write
    send(r_type('h00, 0, 22, 0, 2));
    send(r_type('h20, 0, 23, 0, 2));
    send(i_type(RV_OP_IMM, 6, 24, 0, 'h55));
    end_test();
  endtask

  task automatic test_chain();
    int prev;
    int rd;
    begin_test("dep_chain");
    send(i_type(RV_OP_IMM, 0, 17, 0, 3));
    prev = 17;
    for (int i = 0; i < 8; i++) begin
      rd = 18 + (i % 4);
      send(r_type('h00, 0, rd, prev, 17));
      prev = rd;
    end
    end_test();
  endtask

  task automatic test_loads();
    begin_test("loads");
    send(i_type(RV_LOAD, 2, 23, 2, 16));
    send(i_type(RV_LOAD, 2, 24, 1, -8));
    send(r_type('h00, 0, 25, 23, 24));   // Waits on both loads
    send(i_type(RV_LOAD, 2, 26, 25, 4));
    send(r_type('h00, 4, 27, 26, 1));
    send(i_type(RV_LOAD, 2, 28, 26, 0));
    end_test();
  endtask

  task automatic test_load_pressure();
    begin_test("load_pressure");
    gap_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      // Bursts of independent loads so the table fills up
      send(i_type(RV_LOAD, 2, 5 + (i % 6), 1 + (i % 2), 4 * i - 16));
      if (i % 6 == 5) begin
        for (int j = 0; j < 3; j++) begin
          send(r_type('h00, 0, 12 + j, 5 + 2 * j, 2));  // Waits on a load
          send(i_type(RV_OP_IMM, 0, 27, 27, 1));
        end
      end
    end
    // Read back every register through the write port
    for (int r = 1; r < 32; r++) begin
      send(i_type(RV_OP_IMM, 0, r, r, 0));
    end
    end_test();
    gap_en = 1'b0;
  endtask

  task automatic test_illegal();
    begin_test("illegal");
    send(32'h0000_0000);
    send(32'hFFFF_FFFF);
    send({7'h00, 5'd2, 5'd1, 3'd2, 5'd4, 7'b0100011});  // SW
    send(r_type('h01, 0, 9, 1, 2));                        // MUL
    send(i_type(RV_LOAD, 0, 9, 2, 0));                     // LB
    send(i_type(RV_OP_IMM, 1, 9, 1, 'h405));
    send(i_type(RV_OP_IMM, 0, 9, 9, 1));
    send(i_type(RV_OP_IMM, 0, 0, 0, 0));                   // NOP
    drain();
    check("illegal pulses", 64'(n_illegal), 64'(ilegl_cnt));
    end_test();
  endtask

  initial begin
    for (int r = 0; r < 32; r++) begin
      ref_rf[r] = 32'h0;
    end
    repeat (2) @(posedge clk);
    #1;
    i_rst = 1'b0;
    @(negedge clk);
    check("reset outputs", 64'd0, 64'({o_lsu_cmd_valid, o_wbck.ena, o_ilegl}));
    @(posedge clk);
    #1;
    test_alu_ops();
    test_x0();
    test_chain();
    test_loads();
    test_load_pressure();
    test_illegal();
    $display("%0d tests, %0d checks, %0d errors", n_tests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
src/exu_pkg.sv
src/exu_decode.sv
src/exu_regfile.sv
src/exu_execute.sv
src/exu_oitf.sv
src/exu_wbck.sv
src/exu_top.sv
tb/tb_exu.sv

// File: Makefile
SIM := obj_dir/Vtb_exu

all: run

$(SIM): vlog.f $(wildcard src/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing -f vlog.f --top-module tb_exu -o Vtb_exu

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
